//--- isa_pkg.sv
//////////////////////////////
// RV32I subset definitions
// Widths, major opcodes, ALU operations
// and the NOP encoding
//////////////////////////////
package isa_pkg;

  // Data and address width
  parameter int XLEN = 32;

  // Register index width and register count
  parameter int REG_ADDR_W = 5;
  parameter int NUM_REGS   = 32;

  // Major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // ADDI x0,x0,0, fed into decode on a flush
  parameter logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;

endpackage

//--- pipe_pkg.sv
//////////////////////////////
// Pipeline control definitions
// Controller states, forwarding sources
//////////////////////////////
package pipe_pkg;

  // Controller FSM
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_RUN,
    CTRL_HALTED
  } ctrl_state_e;

  // Operand source in ID
  typedef enum logic [1:0] {
    // Register file read
    FWD_RF,
    // Result of the instruction in EX
    FWD_EX,
    // EX/WB register
    FWD_WB
  } fwd_sel_e;

endpackage

//--- rv_register_file.sv
`timescale 1ns/1ps
//////////////////////////////
// Register file
// x1..x31, two reads, one write
//////////////////////////////
module rv_register_file (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic [isa_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [isa_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  logic                           we_i,
  input  logic [isa_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [isa_pkg::XLEN-1:0]       wdata_i,
  output logic [isa_pkg::XLEN-1:0]       rdata_a_o,
  output logic [isa_pkg::XLEN-1:0]       rdata_b_o
);
  import isa_pkg::*;

  // No storage behind x0
  logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // WB write lands at the clock edge, forwarding covers that cycle
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- rv_controller.sv
`timescale 1ns/1ps
//////////////////////////////
// Pipeline controller
// Run/halt FSM, forwarding select,
// flush and redirect
//////////////////////////////
module rv_controller (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           fetch_enable_i,
  // Instruction in ID
  input  logic [isa_pkg::REG_ADDR_W-1:0] id_rs1_i,
  input  logic [isa_pkg::REG_ADDR_W-1:0] id_rs2_i,
  input  logic                           id_valid_i,
  // Events from EX
  input  logic                           ex_ecall_i,
  input  logic                           ex_branch_taken_i,
  // Pending writers in EX and WB
  input  logic [isa_pkg::REG_ADDR_W-1:0] ex_rd_i,
  input  logic                           ex_we_i,
  input  logic [isa_pkg::REG_ADDR_W-1:0] wb_rd_i,
  input  logic                           wb_we_i,
  output logic                           fetch_run_o,
  output logic                           pc_set_o,
  output logic                           flush_o,
  output pipe_pkg::fwd_sel_e             fwd_a_sel_o,
  output pipe_pkg::fwd_sel_e             fwd_b_sel_o,
  output logic                           halted_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Source select for one operand, EX wins over WB
  function automatic fwd_sel_e src_sel(input logic [REG_ADDR_W-1:0] rs);
    // x0 is never forwarded
    if (!id_valid_i || rs == '0) begin
      return FWD_RF;
    end else if (ex_we_i && ex_rd_i == rs) begin
      return FWD_EX;
    end else if (wb_we_i && wb_rd_i == rs) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  always_comb begin
    fwd_a_sel_o = src_sel(id_rs1_i);
    fwd_b_sel_o = src_sel(id_rs2_i);
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE: begin
        if (fetch_enable_i) begin
          state_d = CTRL_RUN;
        end
      end
      CTRL_RUN: begin
        // ECALL in EX, stop for good
        if (ex_ecall_i) begin
          state_d = CTRL_HALTED;
        end
      end
      default: state_d = state_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // No strobe once ECALL is in EX
  assign fetch_run_o = (state_q == CTRL_RUN) && !ex_ecall_i;
  assign halted_o    = (state_q == CTRL_HALTED);
  // Redirect only for a branch
  assign pc_set_o    = ex_branch_taken_i;
  // Squash younger work, and keep squashing while halted
  assign flush_o     = ex_branch_taken_i || ex_ecall_i || halted_o;

endmodule

//--- rv_if_stage.sv
`timescale 1ns/1ps
//////////////////////////////
// Fetch stage
// PC, request strobe, stale response
// discard, IF/ID register
//////////////////////////////
module rv_if_stage #(
  parameter logic [isa_pkg::XLEN-1:0] BOOT_ADDR = '0
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     fetch_run_i,
  input  logic                     pc_set_i,
  input  logic [isa_pkg::XLEN-1:0] branch_target_i,
  input  logic                     instr_rvalid_i,
  input  logic [isa_pkg::XLEN-1:0] instr_rdata_i,
  output logic                     instr_req_o,
  output logic [isa_pkg::XLEN-1:0] instr_addr_o,
  output logic                     if_valid_o,
  output logic [isa_pkg::XLEN-1:0] if_instr_o,
  output logic [isa_pkg::XLEN-1:0] if_pc_o
);
  import isa_pkg::*;

  logic [XLEN-1:0] pc_q;
  // Address of the word in flight
  logic [XLEN-1:0] req_pc_q;
  // Word in flight was fetched down the wrong path
  logic            discard_q;

  // One strobe per running cycle
  assign instr_req_o  = fetch_run_i;
  assign instr_addr_o = pc_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q      <= BOOT_ADDR;
      discard_q <= 1'b0;
    end else begin
      if (pc_set_i) begin
        pc_q <= branch_target_i;
      end else if (fetch_run_i) begin
        pc_q <= pc_q + XLEN'(4);
      end
      discard_q <= pc_set_i && fetch_run_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_run_i) begin
      req_pc_q <= pc_q;
    end
  end

  // IF/ID valid
  // Redirect squashes the word arriving now
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      if_valid_o <= 1'b0;
    end else begin
      if_valid_o <= instr_rvalid_i && !discard_q && !pc_set_i;
    end
  end

  // IF/ID payload, word paired with its request address
  always_ff @(posedge clk_i) begin
    if (instr_rvalid_i) begin
      if_instr_o <= instr_rdata_i;
      if_pc_o    <= req_pc_q;
    end
  end

endmodule

//--- rv_id_stage.sv
`timescale 1ns/1ps
//////////////////////////////
// Decode stage
// Decoder, immediates, forwarding
// muxes, ID/EX register
//////////////////////////////
module rv_id_stage (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           flush_i,
  input  logic                           if_valid_i,
  input  logic [isa_pkg::XLEN-1:0]       if_instr_i,
  input  logic [isa_pkg::XLEN-1:0]       if_pc_i,
  input  logic [isa_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [isa_pkg::XLEN-1:0]       rf_rdata_b_i,
  input  pipe_pkg::fwd_sel_e             fwd_a_sel_i,
  input  pipe_pkg::fwd_sel_e             fwd_b_sel_i,
  input  logic [isa_pkg::XLEN-1:0]       ex_result_i,
  input  logic [isa_pkg::XLEN-1:0]       wb_data_i,
  output logic [isa_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [isa_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [isa_pkg::REG_ADDR_W-1:0] rd_o,
  output logic                           valid_o,
  // ID/EX
  output isa_pkg::alu_op_e               ex_alu_op_o,
  output logic [isa_pkg::XLEN-1:0]       ex_op_a_o,
  output logic [isa_pkg::XLEN-1:0]       ex_op_b_o,
  output logic [isa_pkg::XLEN-1:0]       ex_store_data_o,
  output logic [isa_pkg::XLEN-1:0]       ex_imm_o,
  output logic [isa_pkg::XLEN-1:0]       ex_pc_o,
  output logic [isa_pkg::REG_ADDR_W-1:0] ex_rd_o,
  output logic                           ex_we_o,
  output logic                           ex_is_store_o,
  output logic                           ex_is_branch_o,
  output logic                           ex_branch_ne_o,
  output logic                           ex_is_ecall_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam logic [XLEN-1:0] INSTR_ECALL = 32'h0000_0073;

  logic [XLEN-1:0] instr;
  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u;
  logic [XLEN-1:0] rs1_val, rs2_val;
  // Decoded controls
  alu_op_e         alu_op;
  logic [XLEN-1:0] imm;
  logic            use_imm;
  logic            we;
  logic            is_store;
  logic            is_branch;
  logic            is_ecall;

  // Empty or flushed slot decodes as a NOP
  assign instr   = (flush_i || !if_valid_i) ? INSTR_NOP : if_instr_i;
  assign opcode  = opcode_e'(instr[6:0]);
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign rs1_o   = instr[19:15];
  assign rs2_o   = instr[24:20];
  assign rd_o    = instr[11:7];
  assign valid_o = if_valid_i;

  // Immediates, all sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                              input logic [XLEN-1:0] rf_val);
    case (sel)
      FWD_EX:  return ex_result_i;
      FWD_WB:  return wb_data_i;
      default: return rf_val;
    endcase
  endfunction

  always_comb begin
    rs1_val = fwd_mux(fwd_a_sel_i, rf_rdata_a_i);
    rs2_val = fwd_mux(fwd_b_sel_i, rf_rdata_b_i);
  end

  // Decoder, unknown encodings fall out as no-ops
  always_comb begin
    alu_op    = ALU_ADD;
    imm       = imm_i;
    use_imm   = 1'b0;
    we        = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_ecall  = 1'b0;
    case (opcode)
      OPC_OP: begin
        we = 1'b1;
        case (funct3)
          3'b000:  alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
          3'b010:  alu_op = ALU_SLT;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: we = 1'b0;
        endcase
        // Only SUB has a nonzero funct7
        if (funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
          we = 1'b0;
        end
      end
      OPC_OP_IMM: begin
        // ADDI only
        we      = (funct3 == 3'b000);
        use_imm = 1'b1;
      end
      OPC_LUI: begin
        we      = 1'b1;
        alu_op  = ALU_PASS_B;
        imm     = imm_u;
        use_imm = 1'b1;
      end
      OPC_STORE: begin
        // SW only, address comes out of the ALU
        is_store = (funct3 == 3'b010);
        imm      = imm_s;
        use_imm  = 1'b1;
      end
      OPC_BRANCH: begin
        // BEQ and BNE
        is_branch = (funct3[2:1] == 2'b00);
        imm       = imm_b;
      end
      OPC_SYSTEM: is_ecall = (instr == INSTR_ECALL);
      default: ;
    endcase
  end

  // ID/EX control
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_we_o        <= 1'b0;
      ex_is_store_o  <= 1'b0;
      ex_is_branch_o <= 1'b0;
      ex_is_ecall_o  <= 1'b0;
    end else begin
      ex_we_o        <= we;
      ex_is_store_o  <= is_store;
      ex_is_branch_o <= is_branch;
      ex_is_ecall_o  <= is_ecall;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk_i) begin
    ex_alu_op_o     <= alu_op;
    ex_op_a_o       <= rs1_val;
    ex_op_b_o       <= use_imm ? imm : rs2_val;
    ex_store_data_o <= rs2_val;
    ex_imm_o        <= imm;
    ex_pc_o         <= if_pc_i;
    ex_rd_o         <= we ? rd_o : '0;
    ex_branch_ne_o  <= funct3[0];
  end

endmodule

//--- rv_ex_stage.sv
`timescale 1ns/1ps
//////////////////////////////
// Execute stage
// ALU, branch compare and target,
// store strobe, EX/WB register
//////////////////////////////
module rv_ex_stage (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           flush_i,
  // ID/EX
  input  isa_pkg::alu_op_e               alu_op_i,
  input  logic [isa_pkg::XLEN-1:0]       op_a_i,
  input  logic [isa_pkg::XLEN-1:0]       op_b_i,
  input  logic [isa_pkg::XLEN-1:0]       store_data_i,
  input  logic [isa_pkg::XLEN-1:0]       imm_i,
  input  logic [isa_pkg::XLEN-1:0]       pc_i,
  input  logic [isa_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic                           we_i,
  input  logic                           is_store_i,
  input  logic                           is_branch_i,
  input  logic                           branch_ne_i,
  input  logic                           is_ecall_i,
  output logic                           ecall_o,
  output logic                           branch_taken_o,
  output logic [isa_pkg::XLEN-1:0]       branch_target_o,
  // Forwarding from EX
  output logic [isa_pkg::REG_ADDR_W-1:0] ex_rd_o,
  output logic                           ex_we_o,
  output logic [isa_pkg::XLEN-1:0]       ex_result_o,
  // EX/WB, register file write
  output logic [isa_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic                           wb_we_o,
  output logic [isa_pkg::XLEN-1:0]       wb_data_o,
  // Store port
  output logic                           data_req_o,
  output logic [isa_pkg::XLEN-1:0]       data_addr_o,
  output logic [isa_pkg::XLEN-1:0]       data_wdata_o
);
  import isa_pkg::*;

  logic [XLEN-1:0] alu_result;

  always_comb begin
    case (alu_op_i)
      ALU_SUB:    alu_result = op_a_i - op_b_i;
      ALU_AND:    alu_result = op_a_i & op_b_i;
      ALU_OR:     alu_result = op_a_i | op_b_i;
      ALU_XOR:    alu_result = op_a_i ^ op_b_i;
      ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
      ALU_PASS_B: alu_result = op_b_i;
      default:    alu_result = op_a_i + op_b_i;
    endcase
  end

  // BEQ on equal, BNE on not equal
  assign branch_taken_o  = is_branch_i && ((op_a_i == op_b_i) != branch_ne_i);
  assign branch_target_o = pc_i + imm_i;
  assign ecall_o         = is_ecall_i;

  assign ex_rd_o     = rd_i;
  assign ex_we_o     = we_i;
  assign ex_result_o = alu_result;

  // Write and store strobes
  // A branch or ECALL in EX has neither, so a flush drops both
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_we_o    <= 1'b0;
      data_req_o <= 1'b0;
    end else begin
      wb_we_o    <= we_i && !flush_i;
      data_req_o <= is_store_i && !flush_i;
    end
  end

  // EX/WB and store payload
  always_ff @(posedge clk_i) begin
    wb_rd_o      <= rd_i;
    wb_data_o    <= alu_result;
    data_addr_o  <= alu_result;
    data_wdata_o <= store_data_i;
  end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps
//////////////////////////////
// Four-step RV32I core top level
// Controller, IF, ID, EX and register file
//////////////////////////////
module rv_core #(
  parameter logic [isa_pkg::XLEN-1:0] BOOT_ADDR = '0
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     fetch_enable_i,
  // Instruction port
  input  logic                     instr_rvalid_i,
  input  logic [isa_pkg::XLEN-1:0] instr_rdata_i,
  output logic                     instr_req_o,
  output logic [isa_pkg::XLEN-1:0] instr_addr_o,
  // Data port, stores only
  output logic                     data_req_o,
  output logic [isa_pkg::XLEN-1:0] data_addr_o,
  output logic [isa_pkg::XLEN-1:0] data_wdata_o,
  output logic                     halted_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  // Controller outputs
  logic     fetch_run;
  logic     pc_set;
  logic     flush;
  fwd_sel_e fwd_a_sel;
  fwd_sel_e fwd_b_sel;

  // IF/ID
  logic            if_valid;
  logic [XLEN-1:0] if_instr;
  logic [XLEN-1:0] if_pc;

  // Decode side
  logic [REG_ADDR_W-1:0] id_rs1;
  logic [REG_ADDR_W-1:0] id_rs2;
  logic                  id_valid;
  logic [XLEN-1:0]       rf_rdata_a;
  logic [XLEN-1:0]       rf_rdata_b;

  // ID/EX
  alu_op_e               idex_alu_op;
  logic [XLEN-1:0]       idex_op_a, idex_op_b, idex_store_data;
  logic [XLEN-1:0]       idex_imm, idex_pc;
  logic [REG_ADDR_W-1:0] idex_rd;
  logic                  idex_we, idex_is_store, idex_is_branch;
  logic                  idex_branch_ne, idex_is_ecall;

  // EX results, forwarding and EX/WB
  logic                  ex_ecall;
  logic                  branch_taken;
  logic [XLEN-1:0]       branch_target;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic                  ex_we;
  logic [XLEN-1:0]       ex_result;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic                  wb_we;
  logic [XLEN-1:0]       wb_data;

  //////////////////////////////
  // Control
  //////////////////////////////
  rv_controller controller_i (
    .clk_i (clk_i), .reset_i (reset_i), .fetch_enable_i (fetch_enable_i),
    .id_rs1_i (id_rs1), .id_rs2_i (id_rs2), .id_valid_i (id_valid),
    .ex_ecall_i (ex_ecall), .ex_branch_taken_i (branch_taken),
    .ex_rd_i (ex_rd), .ex_we_i (ex_we), .wb_rd_i (wb_rd), .wb_we_i (wb_we),
    .fetch_run_o (fetch_run), .pc_set_o (pc_set), .flush_o (flush),
    .fwd_a_sel_o (fwd_a_sel), .fwd_b_sel_o (fwd_b_sel), .halted_o (halted_o)
  );

  //////////////////////////////
  // Fetch
  //////////////////////////////
  rv_if_stage #(
    .BOOT_ADDR (BOOT_ADDR)
  ) if_stage_i (
    .clk_i (clk_i), .reset_i (reset_i),
    .fetch_run_i (fetch_run), .pc_set_i (pc_set), .branch_target_i (branch_target),
    .instr_rvalid_i (instr_rvalid_i), .instr_rdata_i (instr_rdata_i),
    .instr_req_o (instr_req_o), .instr_addr_o (instr_addr_o),
    .if_valid_o (if_valid), .if_instr_o (if_instr), .if_pc_o (if_pc)
  );

  //////////////////////////////
  // Decode and operand read
  //////////////////////////////
  rv_id_stage id_stage_i (
    .clk_i (clk_i), .reset_i (reset_i), .flush_i (flush),
    .if_valid_i (if_valid), .if_instr_i (if_instr), .if_pc_i (if_pc),
    .rf_rdata_a_i (rf_rdata_a), .rf_rdata_b_i (rf_rdata_b),
    .fwd_a_sel_i (fwd_a_sel), .fwd_b_sel_i (fwd_b_sel),
    .ex_result_i (ex_result), .wb_data_i (wb_data),
    // Destination index is carried inside ID/EX
    .rs1_o (id_rs1), .rs2_o (id_rs2), .rd_o (), .valid_o (id_valid),
    .ex_alu_op_o (idex_alu_op), .ex_op_a_o (idex_op_a), .ex_op_b_o (idex_op_b),
    .ex_store_data_o (idex_store_data), .ex_imm_o (idex_imm), .ex_pc_o (idex_pc),
    .ex_rd_o (idex_rd), .ex_we_o (idex_we), .ex_is_store_o (idex_is_store),
    .ex_is_branch_o (idex_is_branch), .ex_branch_ne_o (idex_branch_ne),
    .ex_is_ecall_o (idex_is_ecall)
  );

  rv_register_file register_file_i (
    .clk_i (clk_i), .reset_i (reset_i),
    .raddr_a_i (id_rs1), .raddr_b_i (id_rs2),
    .we_i (wb_we), .waddr_i (wb_rd), .wdata_i (wb_data),
    .rdata_a_o (rf_rdata_a), .rdata_b_o (rf_rdata_b)
  );

  //////////////////////////////
  // Execute, store issue, WB
  //////////////////////////////
  rv_ex_stage ex_stage_i (
    .clk_i (clk_i), .reset_i (reset_i), .flush_i (flush),
    .alu_op_i (idex_alu_op), .op_a_i (idex_op_a), .op_b_i (idex_op_b),
    .store_data_i (idex_store_data), .imm_i (idex_imm), .pc_i (idex_pc),
    .rd_i (idex_rd), .we_i (idex_we), .is_store_i (idex_is_store),
    .is_branch_i (idex_is_branch), .branch_ne_i (idex_branch_ne),
    .is_ecall_i (idex_is_ecall),
    .ecall_o (ex_ecall), .branch_taken_o (branch_taken), .branch_target_o (branch_target),
    .ex_rd_o (ex_rd), .ex_we_o (ex_we), .ex_result_o (ex_result),
    .wb_rd_o (wb_rd), .wb_we_o (wb_we), .wb_data_o (wb_data),
    .data_req_o (data_req_o), .data_addr_o (data_addr_o), .data_wdata_o (data_wdata_o)
  );

endmodule

//--- tb_rv_program.svh
//////////////////////////////
// Test program for the core
// Instruction encoders, random program
// builder, instruction-level reference
//////////////////////////////
`ifndef TB_RV_PROGRAM_SVH
`define TB_RV_PROGRAM_SVH

localparam int PROG_MAX = 128;

// Program image with word 0 at BOOT_ADDR
logic [31:0] prog [0:PROG_MAX-1];
int          prog_len = 0;
int          seed = 63;

// Expected store stream and taken branch targets
logic [31:0] exp_addr_q [$];
logic [31:0] exp_data_q [$];
logic [31:0] target_q [$];

function automatic logic [31:0] rnd();
  return $random(seed);
endfunction

// Any of x1..x31
function automatic logic [4:0] rnd_reg();
  return 5'(1 + rnd() % 31);
endfunction

function automatic void emit(input logic [31:0] w);
  prog[prog_len] = w;
  prog_len++;
endfunction

//////////////////////////////
// Encoders
//////////////////////////////
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input opcode_e opc);
  return {imm, rs1, f3, rd, opc};
endfunction

// SW only
function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, OPC_LUI};
endfunction

// Register-register op picked by sel
function automatic logic [31:0] alu_word(input logic [2:0] sel, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [4:0] rd);
  case (sel)
    3'd1:       return enc_r(7'h20, rs2, rs1, 3'b000, rd);
    3'd2:       return enc_r(7'h00, rs2, rs1, 3'b111, rd);
    3'd3:       return enc_r(7'h00, rs2, rs1, 3'b110, rd);
    3'd4:       return enc_r(7'h00, rs2, rs1, 3'b100, rd);
    3'd5, 3'd6: return enc_r(7'h00, rs2, rs1, 3'b010, rd);
    default:    return enc_r(7'h00, rs2, rs1, 3'b000, rd);
  endcase
endfunction

//////////////////////////////
// Program builder
//////////////////////////////
function automatic void build_program();
  logic [4:0]  rd, rs1, rs2, ra, rb, prev1, prev2;
  logic [31:0] r;
  prev1 = 5'd1;
  prev2 = 5'd2;
  // Dependent ALU block whose sources lean on the last two results
  // Last result goes to x0 just before x0 is stored
  for (int i = 0; i < 40; i++) begin
    r   = rnd();
    rd  = (i % 13 == 6 || i == 39) ? 5'd0 : rnd_reg();
    rs1 = r[0] ? prev1 : rnd_reg();
    rs2 = r[1] ? prev2 : rnd_reg();
    case (r[3:2])
      2'd0, 2'd1: emit(alu_word(r[10:8], rs2, rs1, rd));
      2'd2:       emit(enc_i(r[31:20], rs1, 3'b000, rd, OPC_OP_IMM));
      default:    emit(enc_u(r[31:12], rd));
    endcase
    prev2 = prev1;
    prev1 = rd;
  end
  // Dump of every register including x0
  for (int k = 0; k < 32; k++) begin
    emit(enc_s(12'(12'h400 + 4 * k), 5'(k), 5'd0));
  end
  // Branch groups
  // ADDI, branch over two shadow stores, store at the target
  for (int g = 0; g < 8; g++) begin
    r  = rnd();
    ra = rnd_reg();
    rb = rnd_reg();
    emit(enc_i(r[2] ? 12'h000 : r[31:20], rb, 3'b000, ra, OPC_OP_IMM));
    // r[0] turns BEQ into BNE and r[1] compares ra with itself
    emit(enc_b(13'd12, r[1] ? ra : rb, ra, {2'b00, r[0]}));
    emit(enc_s(12'(12'h600 + 8 * g), ra, 5'd0));
    emit(enc_s(12'(12'h604 + 8 * g), rb, 5'd0));
    emit(enc_s(12'(12'h700 + 4 * g), ra, 5'd0));
  end
  emit({25'b0, OPC_SYSTEM});
  // Stores behind the ECALL that never execute
  emit(enc_s(12'h7f0, 5'd1, 5'd0));
  emit(enc_s(12'h7f4, 5'd2, 5'd0));
endfunction

//////////////////////////////
// Reference model
//////////////////////////////
function automatic void run_reference();
  logic [31:0] regs [0:31];
  logic [31:0] w, a, b, pc;
  bit          done;
  foreach (regs[i]) regs[i] = '0;
  pc   = BOOT_ADDR;
  done = 1'b0;
  while (!done && ((pc - BOOT_ADDR) >> 2) < prog_len) begin
    w  = prog[(pc - BOOT_ADDR) >> 2];
    a  = regs[w[19:15]];
    b  = regs[w[24:20]];
    pc = pc + 32'd4;
    case (w[6:0])
      OPC_OP: begin
        case (w[14:12])
          3'b000:  regs[w[11:7]] = w[30] ? a - b : a + b;
          3'b010:  regs[w[11:7]] = {31'b0, $signed(a) < $signed(b)};
          3'b100:  regs[w[11:7]] = a ^ b;
          3'b110:  regs[w[11:7]] = a | b;
          default: regs[w[11:7]] = a & b;
        endcase
      end
      OPC_OP_IMM: regs[w[11:7]] = a + {{20{w[31]}}, w[31:20]};
      OPC_LUI:    regs[w[11:7]] = {w[31:12], 12'b0};
      OPC_STORE: begin
        exp_addr_q.push_back(a + {{20{w[31]}}, w[31:25], w[11:7]});
        exp_data_q.push_back(b);
      end
      OPC_BRANCH: begin
        // funct3 bit 0 inverts the equality test
        if ((a == b) != w[12]) begin
          pc = pc - 32'd4 + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          target_q.push_back(pc);
        end
      end
      OPC_SYSTEM: done = 1'b1;
      default: ;
    endcase
    // x0 stays zero whatever was written
    regs[0] = '0;
  end
endfunction

`endif

//--- tb_rv_core.sv
`timescale 1ns/1ps
//////////////////////////////
// Testbench for the RV32I core
// Clock, reset, instruction memory,
// fetch and store monitor, timeout
//////////////////////////////
module tb_rv_core;
  import isa_pkg::*;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_0100;

  // DUT inputs
  logic        clk_i          = 1'b0;
  logic        reset_i        = 1'b1;
  logic        fetch_enable_i = 1'b0;
  logic        instr_rvalid_i = 1'b0;
  logic [31:0] instr_rdata_i  = '0;
  // DUT outputs
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        data_req_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic        halted_o;

  int          errors      = 0;
  int          store_idx   = 0;
  int          fetches     = 0;
  int          cycles      = 0;
  int          cycle_limit = 1000;
  logic        fetch_seen  = 1'b0;
  logic [31:0] last_fetch  = '0;
  // Strobe waiting for its response
  logic        pend_valid  = 1'b0;
  logic [31:0] pend_addr   = '0;

  `include "tb_rv_program.svh"

  rv_core #(
    .BOOT_ADDR (BOOT_ADDR)
  ) dut_i (
    .clk_i (clk_i), .reset_i (reset_i), .fetch_enable_i (fetch_enable_i),
    .instr_rvalid_i (instr_rvalid_i), .instr_rdata_i (instr_rdata_i),
    .instr_req_o (instr_req_o), .instr_addr_o (instr_addr_o),
    .data_req_o (data_req_o), .data_addr_o (data_addr_o),
    .data_wdata_o (data_wdata_o), .halted_o (halted_o)
  );

  always #50 clk_i = ~clk_i;

  // Program word, or a filler built from the address outside the image
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - BOOT_ADDR) >> 2;
    if (addr >= BOOT_ADDR && idx < prog_len) begin
      return prog[idx];
    end
    return ~addr;
  endfunction

  function automatic bit is_target(input logic [31:0] addr);
    bit hit;
    hit = 1'b0;
    foreach (target_q[i]) begin
      if (target_q[i] == addr) hit = 1'b1;
    end
    return hit;
  endfunction

  //////////////////////////////
  // Instruction memory
  //////////////////////////////
  // Response lands one cycle after its strobe
  always @(negedge clk_i) begin
    instr_rvalid_i = pend_valid;
    instr_rdata_i  = pend_valid ? word_at(pend_addr) : '0;
    pend_valid     = !reset_i && (instr_req_o === 1'b1);
    pend_addr      = instr_addr_o;
  end

  //////////////////////////////
  // Monitor
  //////////////////////////////
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (instr_req_o) begin
        // First word at boot, then sequential unless redirected
        if (!fetch_seen) begin
          assert (instr_addr_o == BOOT_ADDR) else begin
            errors++;
            $display("ERROR instr_addr_o expected %h got %h", BOOT_ADDR, instr_addr_o);
          end
        end else begin
          assert (instr_addr_o == last_fetch + 32'd4 || is_target(instr_addr_o)) else begin
            errors++;
            $display("ERROR instr_addr_o expected %h got %h", last_fetch + 32'd4,
                     instr_addr_o);
          end
        end
        fetch_seen = 1'b1;
        last_fetch = instr_addr_o;
        fetches++;
      end
      if (data_req_o) begin
        assert (store_idx < exp_addr_q.size()) else begin
          errors++;
          $display("Unexpected store to %h after all expected stores", data_addr_o);
        end
        if (store_idx < exp_addr_q.size()) begin
          assert (data_addr_o == exp_addr_q[store_idx]) else begin
            errors++;
            $display("ERROR data_addr_o expected %h got %h", exp_addr_q[store_idx],
                     data_addr_o);
          end
          assert (data_wdata_o == exp_data_q[store_idx]) else begin
            errors++;
            $display("ERROR data_wdata_o expected %h got %h", exp_data_q[store_idx],
                     data_wdata_o);
          end
        end
        store_idx++;
      end
      // Halted core keeps both ports quiet
      if (halted_o) begin
        assert (!instr_req_o && !data_req_o) else begin
          errors++;
          $display("Port strobe seen while the core is halted");
        end
      end
    end
  end

  // Cycle limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the core never halted", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  //////////////////////////////
  // Sequence
  //////////////////////////////
  initial begin
    build_program();
    run_reference();
    cycle_limit = 4 * prog_len + 100;
    $display("Program of %0d words, %0d stores expected", prog_len, exp_addr_q.size());
    repeat (2) @(negedge clk_i);
    reset_i = 1'b0;
    // Idle with fetch disabled
    repeat (3) begin
      @(negedge clk_i);
      assert (!instr_req_o && !data_req_o && !halted_o) else begin
        errors++;
        $display("Core active while fetch_enable_i is low");
      end
    end
    fetch_enable_i = 1'b1;
    while (halted_o !== 1'b1) begin
      @(negedge clk_i);
    end
    // Let the monitor watch a quiet pipeline
    // Halt holds until the next reset
    repeat (8) begin
      @(negedge clk_i);
      assert (halted_o === 1'b1) else begin
        errors++;
        $display("ERROR halted_o expected %h got %h", 1'b1, halted_o);
      end
    end
    assert (store_idx == exp_addr_q.size()) else begin
      errors++;
      $display("Store count %0d differs from the expected %0d", store_idx,
               exp_addr_q.size());
    end
    $display("Fetches %0d, stores %0d of %0d, errors %0d", fetches, store_idx,
             exp_addr_q.size(), errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
rv_register_file.sv
rv_controller.sv
rv_if_stage.sv
rv_id_stage.sv
rv_ex_stage.sv
rv_core.sv
tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_rv_core -f project.f -o tb_rv_core

./obj_dir/tb_rv_core | tee "$log"

if grep -q "Testbench failed" "$log"; then
  echo "Simulation reported a failure, see $log"
  exit 1
fi
echo "Simulation finished, log in $log"
